//--- rs_csee_top.f
rs_gf32_pkg.sv
csee_if.sv
coef_wb_slave.sv
symbol_store.sv
chien_cell.sv
csee_block.sv
error_corrector.sv
rs_csee_top.sv
tb_rs_csee_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the RS CSEE testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_rs_csee_top -f rs_csee_top.f -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

//--- tb_rs_csee_top.sv
`timescale 1ns/100ps
// Self-checking testbench for the Reed-Solomon GF(2^5) Chien search back end
// Random words, error locators and output stalls checked against a table-based field model
module tb_rs_csee_top;
    import rs_gf32_pkg::*;

    localparam int NUM_WORDS  = 10;
    // Words times symbols times a generous per-symbol allowance for bus traffic and stalls
    localparam int TIMEOUT_NS = NUM_WORDS * CODE_LEN * 16 * 8 + 1000;

    logic                   clock2 = 1'b0;
    logic                   reset;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [WB_ADR_BITS-1:0] wb_adr;
    logic [7:0]             wb_dat_w;
    logic [7:0]             wb_dat_r;
    logic                   wb_ack;
    logic                   out_ready = 1'b0;
    logic                   out_valid;
    gf_sym_t                out_symbol;
    logic [STEP_BITS-1:0]   out_index;

    integer  seed;
    // Field model tables for x^5 + x^2 + 1
    gf_sym_t exp_tab [31];
    int      log_tab [32];
    // Current word, its coefficients and expected output
    gf_sym_t rx [CODE_LEN];
    gf_sym_t lam [LAMBDA_TERMS];
    gf_sym_t omg [OMEGA_TERMS];
    gf_sym_t expect_sym [CODE_LEN];
    // Stall pattern for out_ready drawn once from the seed
    bit         ready_pat [256];
    logic [7:0] ready_cyc = '0;
    logic       stall_en = 1'b0;
    int         word_num = 0;
    int         bus_errors = 0;
    int         status_errors = 0;
    // Owned by the output monitor
    int         value_errors = 0;
    int         checked = 0;
    int         got = 0;
    int         next_index = 0;
    int         seen_word = 0;
    bit         stalled = 1'b0;
    gf_sym_t    held_sym;
    logic [STEP_BITS-1:0] held_idx;

    rs_csee_top rs_csee_top_inst (
        .clock2     (clock2),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_symbol (out_symbol),
        .out_index  (out_index)
    );

    always #4 clock2 = ~clock2;

    // Sink is always ready until stalls are switched on
    always @(posedge clock2) begin
        out_ready <= stall_en ? ready_pat[ready_cyc] : 1'b1;
        ready_cyc <= ready_cyc + 8'd1;
    end

    // Build antilog and log tables by repeated multiplication by alpha
    function automatic void make_tables();
        logic [5:0] v;
        v = 6'd1;
        for (int i = 0; i < 31; i++) begin
            exp_tab[i] = v[4:0];
            log_tab[v[4:0]] = i;
            v = v << 1;
            if (v[5])
                v = v ^ 6'b100101;
        end
    endfunction

    function automatic gf_sym_t alpha_to(input int k);
        return exp_tab[((k % 31) + 31) % 31];
    endfunction

    function automatic gf_sym_t mult(input gf_sym_t a, input gf_sym_t b);
        if (a == '0 || b == '0)
            return '0;
        return exp_tab[(log_tab[a] + log_tab[b]) % 31];
    endfunction

    // Zero divisor gives zero like the hardware inverse
    function automatic gf_sym_t divide(input gf_sym_t a, input gf_sym_t b);
        if (a == '0 || b == '0)
            return '0;
        return exp_tab[(log_tab[a] - log_tab[b] + 31) % 31];
    endfunction

    // Ack must come exactly one cycle after the request
    task automatic await_ack();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clock2);
            cycles++;
        end while (!wb_ack && cycles < 16);
        if (!wb_ack) begin
            $display("Wishbone request at address %0d was never acknowledged", wb_adr);
            bus_errors++;
        end else if (cycles != 2) begin
            $display("** Error at %0t: ack %0d cycles after request, expected 1",
                     $time, cycles - 1);
            bus_errors++;
        end
    endtask

    task automatic write_reg(input logic [WB_ADR_BITS-1:0] adr, input logic [7:0] data);
        @(posedge clock2);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= data;
        await_ack();
        @(posedge clock2);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic read_reg(input logic [WB_ADR_BITS-1:0] adr, output logic [7:0] data);
        @(posedge clock2);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        await_ack();
        data = wb_dat_r;
        @(posedge clock2);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    // Coefficient registers read back only their low 5 bits
    task automatic check_coef(input logic [WB_ADR_BITS-1:0] adr, input gf_sym_t want);
        logic [7:0] data;
        read_reg(adr, data);
        if (data != {3'b000, want}) begin
            $display("** Error at %0t: coefficient at %0d reads %h, expected %h",
                     $time, adr, data, {3'b000, want});
            bus_errors++;
        end
    endtask

    // Loads one word, starts it and checks the status once busy clears
    task automatic run_word(input int num_err, input bit poke_ctrl);
        bit [30:0]  used;
        int         p;
        int         n;
        logic [7:0] status;
        gf_sym_t    lo;
        gf_sym_t    le;
        gf_sym_t    om;
        gf_sym_t    x;
        for (int i = 0; i < CODE_LEN; i++)
            rx[i] = 5'($random(seed));
        for (int d = 0; d < LAMBDA_TERMS; d++)
            lam[d] = '0;
        lam[0] = 5'd1;
        // Lambda as the product of (1 + alpha^-p x) over distinct positions
        used = '0;
        n    = 0;
        while (n < num_err) begin
            p = $unsigned($random(seed)) % 31;
            if (!used[p]) begin
                used[p] = 1'b1;
                n++;
                for (int d = LAMBDA_TERMS - 1; d > 0; d--)
                    lam[d] = lam[d] ^ mult(alpha_to(-p), lam[d-1]);
            end
        end
        for (int d = 0; d < OMEGA_TERMS; d++)
            omg[d] = 5'($random(seed));
        // Expected symbols carry the Forney value only at roots
        for (int j = 0; j < CODE_LEN; j++) begin
            lo = '0;
            le = '0;
            om = '0;
            for (int d = 0; d < LAMBDA_TERMS; d++) begin
                x = mult(lam[d], alpha_to(d * j));
                if (d % 2 == 1)
                    lo = lo ^ x;
                else
                    le = le ^ x;
            end
            for (int d = 0; d < OMEGA_TERMS; d++)
                om = om ^ mult(omg[d], alpha_to(d * j));
            expect_sym[j] = rx[j];
            if ((lo ^ le) == '0)
                expect_sym[j] = rx[j] ^ divide(om, lo);
        end
        for (int i = 0; i < CODE_LEN; i++)
            write_reg(6'(i), {3'b000, rx[i]});
        // Upper bus bits are junk the registers must drop
        for (int d = 0; d < LAMBDA_TERMS; d++)
            write_reg(ADR_LAMBDA_BASE + 6'(d), {3'($random(seed)), lam[d]});
        for (int d = 0; d < OMEGA_TERMS; d++)
            write_reg(ADR_OMEGA_BASE + 6'(d), {3'($random(seed)), omg[d]});
        for (int d = 0; d < LAMBDA_TERMS; d++)
            check_coef(ADR_LAMBDA_BASE + 6'(d), lam[d]);
        for (int d = 0; d < OMEGA_TERMS; d++)
            check_coef(ADR_OMEGA_BASE + 6'(d), omg[d]);
        word_num <= word_num + 1;
        write_reg(ADR_CTRL, 8'h01);
        // A second start while running must be dropped
        if (poke_ctrl)
            write_reg(ADR_CTRL, 8'h01);
        read_reg(ADR_CTRL, status);
        if (!status[3]) begin
            $display("** Error at %0t: busy flag clear after the start write", $time);
            status_errors++;
        end
        do
            read_reg(ADR_CTRL, status);
        while (status[3]);
        if (got != CODE_LEN) begin
            $display("** Error at %0t: word delivered %0d symbols, expected %0d",
                     $time, got, CODE_LEN);
            status_errors++;
        end
        if (status[2:0] != 3'(num_err)) begin
            $display("** Error at %0t: root count %0d, expected %0d",
                     $time, status[2:0], num_err);
            status_errors++;
        end
    endtask

    // Output monitor samples midway between rising edges
    always @(negedge clock2) begin
        if (word_num != seen_word) begin
            seen_word  = word_num;
            next_index = 0;
            got        = 0;
            stalled    = 1'b0;
        end
        if (reset) begin
            // A stalled output must stay put until it is taken
            if (stalled && (!out_valid || out_symbol != held_sym || out_index != held_idx)) begin
                $display("** Error at %0t: output changed while stalled", $time);
                value_errors++;
            end
            stalled  = out_valid && !out_ready;
            held_sym = out_symbol;
            held_idx = out_index;
            if (out_valid && out_ready) begin
                if (next_index >= CODE_LEN) begin
                    $display("** Error at %0t: extra symbol with index %0d", $time, out_index);
                    value_errors++;
                end else if (out_index != 5'(next_index)) begin
                    $display("** Error at %0t: index %0d, expected %0d",
                             $time, out_index, next_index);
                    value_errors++;
                end else if (out_symbol != expect_sym[next_index]) begin
                    $display("** Error at %0t: symbol %0d is %h, expected %h",
                             $time, next_index, out_symbol, expect_sym[next_index]);
                    value_errors++;
                end
                next_index++;
                got++;
                checked++;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Simulation timed out before all words were checked");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        seed     = 92;
        reset    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        make_tables();
        for (int i = 0; i < 256; i++)
            ready_pat[i] = ($random(seed) & 3) != 0;
        repeat (2) @(posedge clock2);
        reset <= 1'b1;
        // Word 0 error free, word 1 without stalls, the rest with stalls
        for (int w = 0; w < NUM_WORDS; w++) begin
            stall_en <= (w >= 2);
            run_word((w == 0) ? 0 : $unsigned($random(seed)) % 7, (w % 3) == 2);
        end
        repeat (4) @(posedge clock2);
        $display("Summary: %0d value errors, %0d bus errors, %0d status errors, %0d symbols",
                 value_errors, bus_errors, status_errors, checked);
        if (value_errors + bus_errors + status_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- rs_csee_top.sv
`timescale 1ns/100ps
// Reed-Solomon GF(2^5) Chien search and correction back end
// Wishbone slave in, corrected symbol stream out
module rs_csee_top (
    input  logic                                clock2,
    input  logic                                reset,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [rs_gf32_pkg::WB_ADR_BITS-1:0] wb_adr,
    input  logic [7:0]                          wb_dat_w,
    output logic [7:0]                          wb_dat_r,
    output logic                                wb_ack,
    input  logic                                out_ready,
    output logic                                out_valid,
    output rs_gf32_pkg::gf_sym_t                out_symbol,
    output logic [rs_gf32_pkg::STEP_BITS-1:0]   out_index
);
    import rs_gf32_pkg::*;

    // Bus to buffer
    logic                 sym_we;
    logic [STEP_BITS-1:0] sym_addr;
    gf_sym_t              sym_data;
    // Buffer to corrector
    logic [STEP_BITS-1:0] rd_index;
    gf_sym_t              rd_symbol;
    // Search to corrector
    logic                 step_valid;
    logic [STEP_BITS-1:0] step_index;
    gf_sym_t              err_value;
    logic                 hold;

    csee_if coef_bus ();

    coef_wb_slave coef_wb_slave_inst (
        .clock2   (clock2),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .sym_we   (sym_we),
        .sym_addr (sym_addr),
        .sym_data (sym_data),
        .coef     (coef_bus.host)
    );

    symbol_store symbol_store_inst (
        .clock2 (clock2),
        .reset  (reset),
        .we     (sym_we),
        .waddr  (sym_addr),
        .wdata  (sym_data),
        .raddr  (rd_index),
        .rdata  (rd_symbol)
    );

    csee_block csee_block_inst (
        .clock2     (clock2),
        .reset      (reset),
        .coef       (coef_bus.search),
        .hold       (hold),
        .step_valid (step_valid),
        .step_index (step_index),
        .err_value  (err_value)
    );

    error_corrector error_corrector_inst (
        .clock2     (clock2),
        .reset      (reset),
        .step_valid (step_valid),
        .step_index (step_index),
        .err_value  (err_value),
        .rd_symbol  (rd_symbol),
        .rd_index   (rd_index),
        .hold       (hold),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_symbol (out_symbol),
        .out_index  (out_index)
    );

endmodule

//--- error_corrector.sv
`timescale 1ns/100ps
// Correction and output stage
// XORs the error value into the buffered symbol, holds under back-pressure
module error_corrector (
    input  logic                              clock2,
    input  logic                              reset,
    input  logic                              step_valid,
    input  logic [rs_gf32_pkg::STEP_BITS-1:0] step_index,
    input  rs_gf32_pkg::gf_sym_t              err_value,
    input  rs_gf32_pkg::gf_sym_t              rd_symbol,
    output logic [rs_gf32_pkg::STEP_BITS-1:0] rd_index,
    output logic                              hold,
    input  logic                              out_ready,
    output logic                              out_valid,
    output rs_gf32_pkg::gf_sym_t              out_symbol,
    output logic [rs_gf32_pkg::STEP_BITS-1:0] out_index
);

    // Buffer lookup follows the step on offer
    assign rd_index = step_index;

    // Output waiting for the sink stalls the search
    assign hold = out_valid & ~out_ready;

    always_ff @(posedge clock2 or negedge reset) begin
        if (!reset)
            out_valid <= 1'b0;
        else if (!hold)
            out_valid <= step_valid;
    end

    always_ff @(posedge clock2) begin
        if (!hold && step_valid) begin
            out_symbol <= rd_symbol ^ err_value;
            out_index  <= step_index;
        end
    end

endmodule

//--- csee_block.sv
`timescale 1ns/100ps
// Chien search with Forney error evaluation over 31 positions
// Finds roots of Lambda and gives Omega / Lambda_odd at each root
module csee_block (
    input  logic                              clock2,
    input  logic                              reset,
    csee_if.search                            coef,
    input  logic                              hold,
    output logic                              step_valid,
    output logic [rs_gf32_pkg::STEP_BITS-1:0] step_index,
    output rs_gf32_pkg::gf_sym_t              err_value
);
    import rs_gf32_pkg::*;

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_SEARCH = 2'd1;
    localparam logic [1:0] ST_DRAIN  = 2'd2;

    logic [1:0]           state;
    logic [STEP_BITS-1:0] step_cnt;
    logic [ROOT_BITS-1:0] root_cnt;
    logic                 load;
    logic                 advance;
    logic                 is_root;
    gf_sym_t              lambda_term [LAMBDA_TERMS];
    gf_sym_t              omega_term [OMEGA_TERMS];
    gf_sym_t              lambda_odd;
    gf_sym_t              lambda_even;
    gf_sym_t              omega_sum;

    assign load    = coef.start & (state == ST_IDLE);
    // Cells, counters and the output stage move together
    assign advance = (state == ST_SEARCH) & ~hold;

    for (genvar d = 0; d < LAMBDA_TERMS; d++) begin : g_lambda
        chien_cell #(.DEGREE(d)) lambda_cell (
            .clock2  (clock2),
            .reset   (reset),
            .load    (load),
            .step    (advance),
            .coef_in (coef.lambda[d]),
            .term    (lambda_term[d])
        );
    end

    for (genvar d = 0; d < OMEGA_TERMS; d++) begin : g_omega
        chien_cell #(.DEGREE(d)) omega_cell (
            .clock2  (clock2),
            .reset   (reset),
            .load    (load),
            .step    (advance),
            .coef_in (coef.omega[d]),
            .term    (omega_term[d])
        );
    end

    // Term sums at alpha^step_cnt
    always_comb begin
        lambda_odd  = '0;
        lambda_even = '0;
        omega_sum   = '0;
        for (int d = 0; d < LAMBDA_TERMS; d++) begin
            if (d % 2 == 1)
                lambda_odd = lambda_odd ^ lambda_term[d];
            else
                lambda_even = lambda_even ^ lambda_term[d];
        end
        for (int d = 0; d < OMEGA_TERMS; d++)
            omega_sum = omega_sum ^ omega_term[d];
    end

    assign is_root = (lambda_odd ^ lambda_even) == '0;

    always_ff @(posedge clock2 or negedge reset) begin
        if (!reset) begin
            state      <= ST_IDLE;
            step_cnt   <= '0;
            root_cnt   <= '0;
            step_valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (coef.start) begin
                        state    <= ST_SEARCH;
                        step_cnt <= '0;
                        root_cnt <= '0;
                    end
                end
                ST_SEARCH: begin
                    if (!hold) begin
                        step_valid <= 1'b1;
                        step_cnt   <= step_cnt + 1'b1;
                        if (is_root)
                            root_cnt <= root_cnt + 1'b1;
                        if (step_cnt == STEP_BITS'(CODE_LEN - 1))
                            state <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    // Hand over the last step, then wait for its transfer
                    if (!hold) begin
                        if (step_valid)
                            step_valid <= 1'b0;
                        else
                            state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Registered step output, zero away from roots
    always_ff @(posedge clock2) begin
        if (advance) begin
            step_index <= step_cnt;
            err_value  <= is_root ? gf_mul(omega_sum, gf_inv(lambda_odd)) : '0;
        end
    end

    assign coef.busy       = state != ST_IDLE;
    assign coef.root_count = root_cnt;

endmodule

//--- chien_cell.sv
`timescale 1ns/100ps
// One Chien/Forney term register
// Loads a coefficient, then scales by alpha^DEGREE each search step
module chien_cell #(
    parameter int DEGREE = 0
) (
    input  logic                 clock2,
    input  logic                 reset,
    input  logic                 load,
    input  logic                 step,
    input  rs_gf32_pkg::gf_sym_t coef_in,
    output rs_gf32_pkg::gf_sym_t term
);
    import rs_gf32_pkg::*;

    always_ff @(posedge clock2 or negedge reset) begin
        if (!reset)
            term <= '0;
        else if (load)
            term <= coef_in;
        // Constant power, folds to a small XOR net
        else if (step)
            term <= gf_mul_alpha_pow(term, DEGREE);
    end

endmodule

//--- symbol_store.sv
`timescale 1ns/100ps
// Buffer for the 31 received symbols
// Written from the bus, read by step index during correction
module symbol_store (
    input  logic                              clock2,
    input  logic                              reset,
    input  logic                              we,
    input  logic [rs_gf32_pkg::STEP_BITS-1:0] waddr,
    input  rs_gf32_pkg::gf_sym_t              wdata,
    input  logic [rs_gf32_pkg::STEP_BITS-1:0] raddr,
    output rs_gf32_pkg::gf_sym_t              rdata
);
    import rs_gf32_pkg::*;

    gf_sym_t             mem [CODE_LEN];
    // Entries written since reset
    logic [CODE_LEN-1:0] written;

    always_ff @(posedge clock2) begin
        if (we)
            mem[waddr] <= wdata;
    end

    always_ff @(posedge clock2 or negedge reset) begin
        if (!reset)
            written <= '0;
        else if (we)
            written[waddr] <= 1'b1;
    end

    // Unwritten slots read as zero
    assign rdata = written[raddr] ? mem[raddr] : '0;

endmodule

//--- coef_wb_slave.sv
`timescale 1ns/100ps
// Wishbone classic slave of the CSEE back end
// Holds lambda/omega, forwards received symbols and launches a run
module coef_wb_slave (
    input  logic                                clock2,
    input  logic                                reset,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [rs_gf32_pkg::WB_ADR_BITS-1:0] wb_adr,
    input  logic [7:0]                          wb_dat_w,
    output logic [7:0]                          wb_dat_r,
    output logic                                wb_ack,
    output logic                                sym_we,
    output logic [rs_gf32_pkg::STEP_BITS-1:0]   sym_addr,
    output rs_gf32_pkg::gf_sym_t                sym_data,
    csee_if.host                                coef
);
    import rs_gf32_pkg::*;

    gf_sym_t    lambda_q [LAMBDA_TERMS];
    gf_sym_t    omega_q [OMEGA_TERMS];
    logic       req;
    logic       wr_en;
    logic       sym_sel;
    logic       lambda_sel;
    logic       omega_sel;
    logic       ctrl_sel;
    logic       start_q;
    logic [7:0] rd_data;

    // Fresh request, ack follows on the next edge
    assign req   = wb_cyc & wb_stb & ~wb_ack;
    assign wr_en = req & wb_we;

    // Address decode, coefficient bases are 8-aligned
    assign sym_sel    = wb_adr < ADR_SYM_BASE + 6'(CODE_LEN);
    assign lambda_sel = (wb_adr >= ADR_LAMBDA_BASE) &&
                        (wb_adr < ADR_LAMBDA_BASE + 6'(LAMBDA_TERMS));
    assign omega_sel  = (wb_adr >= ADR_OMEGA_BASE) &&
                        (wb_adr < ADR_OMEGA_BASE + 6'(OMEGA_TERMS));
    assign ctrl_sel   = wb_adr == ADR_CTRL;

    // Received word is frozen while a run is busy
    assign sym_we   = wr_en & sym_sel & ~coef.busy;
    assign sym_addr = STEP_BITS'(wb_adr - ADR_SYM_BASE);
    assign sym_data = wb_dat_w[4:0];

    always_ff @(posedge clock2 or negedge reset) begin
        if (!reset) begin
            wb_ack  <= 1'b0;
            start_q <= 1'b0;
        end else begin
            wb_ack  <= req;
            // Control write while busy is acked and dropped
            start_q <= wr_en & ctrl_sel & ~coef.busy;
        end
    end

    // Coefficient registers take the low 5 bits of the bus word
    always_ff @(posedge clock2 or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < LAMBDA_TERMS; i++)
                lambda_q[i] <= '0;
            for (int i = 0; i < OMEGA_TERMS; i++)
                omega_q[i] <= '0;
        end else if (wr_en) begin
            for (int i = 0; i < LAMBDA_TERMS; i++) begin
                if (lambda_sel && wb_adr[2:0] == 3'(i))
                    lambda_q[i] <= wb_dat_w[4:0];
            end
            for (int i = 0; i < OMEGA_TERMS; i++) begin
                if (omega_sel && wb_adr[2:0] == 3'(i))
                    omega_q[i] <= wb_dat_w[4:0];
            end
        end
    end

    // Status has busy in bit 3, roots in 2:0
    always_comb begin
        rd_data = 8'h00;
        if (ctrl_sel)
            rd_data = {4'h0, coef.busy, coef.root_count};
        else if (lambda_sel)
            rd_data = {3'b000, lambda_q[wb_adr[2:0]]};
        else if (omega_sel)
            rd_data = {3'b000, omega_q[wb_adr[2:0]]};
    end

    // Read data lines up with ack
    always_ff @(posedge clock2) begin
        if (req)
            wb_dat_r <= rd_data;
    end

    assign coef.lambda = lambda_q;
    assign coef.omega  = omega_q;
    assign coef.start  = start_q;

endmodule

//--- csee_if.sv
`timescale 1ns/100ps
// Coefficient hand-off between the bus slave and the Chien/Forney search
// Carries lambda and omega, the start pulse and the run status
interface csee_if;
    import rs_gf32_pkg::*;

    // Error locator and scaled evaluator coefficients
    gf_sym_t lambda [LAMBDA_TERMS];
    gf_sym_t omega [OMEGA_TERMS];
    // One-cycle run request
    logic start;
    // Run in progress and roots found in the current or last word
    logic busy;
    logic [ROOT_BITS-1:0] root_count;

    modport host (output lambda, output omega, output start,
                  input busy, input root_count);

    modport search (input lambda, input omega, input start,
                    output busy, output root_count);

endinterface

//--- rs_gf32_pkg.sv
// GF(2^5) arithmetic and shared constants for the Reed-Solomon CSEE back end
// Field built on x^5 + x^2 + 1, code length 31, up to six correctable symbols
package rs_gf32_pkg;

    // One field symbol in polynomial basis
    typedef logic [4:0] gf_sym_t;

    localparam int CODE_LEN     = 31;
    localparam int LAMBDA_TERMS = 7;
    localparam int OMEGA_TERMS  = 6;
    localparam int STEP_BITS    = 5;
    localparam int ROOT_BITS    = 3;

    // Wishbone word address map
    localparam int WB_ADR_BITS = 6;
    localparam logic [WB_ADR_BITS-1:0] ADR_SYM_BASE    = 6'd0;
    localparam logic [WB_ADR_BITS-1:0] ADR_LAMBDA_BASE = 6'd32;
    localparam logic [WB_ADR_BITS-1:0] ADR_OMEGA_BASE  = 6'd40;
    localparam logic [WB_ADR_BITS-1:0] ADR_CTRL        = 6'd48;

    // Times alpha, x^5 folds back into x^2 + 1
    function automatic gf_sym_t gf_mul_alpha(input gf_sym_t a);
        return {a[3:0], 1'b0} ^ (a[4] ? 5'b00101 : 5'b00000);
    endfunction

    // Shift-and-add product
    function automatic gf_sym_t gf_mul(input gf_sym_t a, input gf_sym_t b);
        gf_sym_t acc;
        gf_sym_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < 5; i++) begin
            if (b[i])
                acc = acc ^ sh;
            sh = gf_mul_alpha(sh);
        end
        return acc;
    endfunction

    // Product with alpha^k, k taken modulo the group order
    // Negative k gives the inverse power
    function automatic gf_sym_t gf_mul_alpha_pow(input gf_sym_t a, input int k);
        gf_sym_t r;
        int      kk;
        r  = a;
        kk = k % CODE_LEN;
        if (kk < 0)
            kk = kk + CODE_LEN;
        for (int i = 0; i < CODE_LEN; i++) begin
            if (i < kk)
                r = gf_mul_alpha(r);
        end
        return r;
    endfunction

    // a^-1 = a^30 = a^2 * a^4 * a^8 * a^16, zero stays zero
    function automatic gf_sym_t gf_inv(input gf_sym_t a);
        gf_sym_t sq;
        gf_sym_t r;
        sq = a;
        r  = 5'b00001;
        for (int i = 0; i < 4; i++) begin
            sq = gf_mul(sq, sq);
            r  = gf_mul(r, sq);
        end
        return r;
    endfunction

endpackage
